//--- aesPkg.sv
package aesPkg;

	typedef logic [127:0] aesBlock;

	typedef logic [3:0] roundIndex; // round number from 0 to 10.

	// Column c holds bits 32c+31 down to 32c counted from the top, with row 0 as its top byte.
	typedef union packed {
		aesBlock flat;
		logic [0:3][0:3][7:0] col;
	} aesState;

	typedef struct packed {
		aesBlock secretKey;
		aesBlock cipherText;
	} aesRequest;

	localparam logic [0:255][7:0] sBox = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [0:255][7:0] invSBox = {
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	localparam logic [0:9][7:0] roundConstant = {
		8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
		8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
	}; // entry i serves round key i+1.

	function automatic logic [7:0] xtime(input logic [7:0] value);
		return {value[6:0], 1'b0} ^ (value[7] ? 8'h1b : 8'h00); // reduce by 0x11b on overflow.
	endfunction

	// Shift-and-add over the bits of the factor, so 0e, 0b, 0d and 09 all share one path.
	function automatic logic [7:0] gfMul(input logic [7:0] value, input logic [3:0] factor);
		logic [7:0] product;
		logic [7:0] power;
		product = 8'h00;
		power = value;
		for (int i = 0; i < 4; i++) begin
			if (factor[i]) begin
				product = product ^ power;
			end
			power = xtime(power);
		end
		return product;
	endfunction

endpackage

//--- invMixColumns.sv
`timescale 1ns/1ps

module invMixColumns (
	input aesPkg::aesState in,
	output aesPkg::aesState out
);
	import aesPkg::*;

	// Each output row uses the circulant 0e 0b 0d 09, rotated one place per row.
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			out.col[c][0] = gfMul(in.col[c][0], 4'he)
				^ gfMul(in.col[c][1], 4'hb)
				^ gfMul(in.col[c][2], 4'hd)
				^ gfMul(in.col[c][3], 4'h9);
			out.col[c][1] = gfMul(in.col[c][0], 4'h9)
				^ gfMul(in.col[c][1], 4'he)
				^ gfMul(in.col[c][2], 4'hb)
				^ gfMul(in.col[c][3], 4'hd);
			out.col[c][2] = gfMul(in.col[c][0], 4'hd)
				^ gfMul(in.col[c][1], 4'h9)
				^ gfMul(in.col[c][2], 4'he)
				^ gfMul(in.col[c][3], 4'hb);
			out.col[c][3] = gfMul(in.col[c][0], 4'hb)
				^ gfMul(in.col[c][1], 4'hd)
				^ gfMul(in.col[c][2], 4'h9)
				^ gfMul(in.col[c][3], 4'he);
		end
	end

endmodule

//--- invRound.sv
`timescale 1ns/1ps

module invRound (
	input aesPkg::aesState state,
	input aesPkg::aesBlock roundKey,
	input logic lastRound,
	output aesPkg::aesState nextState
);
	import aesPkg::*;

	aesState shifted;
	aesState substituted;
	aesState keyed;
	aesState mixed;

	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted.col[c][r] = state.col[(c + 4 - r) % 4][r]; // row r moves right by r.
			end
		end
	end

	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				substituted.col[c][r] = invSBox[shifted.col[c][r]];
			end
		end
	end

	assign keyed.flat = substituted.flat ^ roundKey;

	invMixColumns mixer (
		.in(keyed),
		.out(mixed)
	);

	assign nextState = lastRound ? keyed : mixed; // the final round has no column mixing.

endmodule

//--- keyExpander.sv
`timescale 1ns/1ps

module keyExpander (
	input logic clk,
	input logic reset,
	input logic load,
	input aesPkg::aesBlock secretKey,
	input aesPkg::roundIndex select,
	output aesPkg::aesBlock roundKey,
	output logic ready
);
	import aesPkg::*;

	aesBlock keyStore [0:10];
	aesBlock workKey; // the key derived most recently.
	aesBlock nextKey;
	roundIndex step; // key step+1 is written on the next edge.
	logic running;
	logic [31:0] lastWord;
	logic [31:0] rotWord;
	logic [31:0] subWord;
	logic [7:0] rcon;

	always_comb begin
		lastWord = workKey[31:0];
		rotWord = {lastWord[23:0], lastWord[31:24]};
		for (int b = 0; b < 4; b++) begin
			subWord[8*b +: 8] = sBox[rotWord[8*b +: 8]];
		end
		rcon = roundConstant[step];
		nextKey[127:96] = workKey[127:96] ^ subWord ^ {rcon, 24'h000000};
		nextKey[95:64] = workKey[95:64] ^ nextKey[127:96];
		nextKey[63:32] = workKey[63:32] ^ nextKey[95:64];
		nextKey[31:0] = workKey[31:0] ^ nextKey[63:32];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			step <= 4'd0;
			running <= 1'b0;
			ready <= 1'b0;
		end else if (load) begin
			step <= 4'd0;
			running <= 1'b1;
			ready <= 1'b0;
		end else if (running) begin
			if (step == 4'd9) begin
				running <= 1'b0; // key 10 lands on this edge.
				ready <= 1'b1;
			end else begin
				step <= step + 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			keyStore[0] <= secretKey;
			workKey <= secretKey;
		end else if (running) begin
			keyStore[step + 4'd1] <= nextKey;
			workKey <= nextKey;
		end
	end

	assign roundKey = keyStore[select];

endmodule

//--- aesDecrypt.sv
`timescale 1ns/1ps

module aesDecrypt (
	input logic clk,
	input logic reset,
	input logic start,
	input aesPkg::aesRequest request,
	output logic busy,
	output logic done,
	output aesPkg::aesBlock plainText
);
	import aesPkg::*;

	logic accept;
	logic waiting; // high until the key schedule reports ready.
	logic keyReady;
	logic lastRound;
	roundIndex round;
	roundIndex select;
	aesBlock roundKey;
	aesBlock cipherText;
	aesState state;
	aesState nextState;

	assign accept = start && !busy; // a start during a block is dropped.
	assign select = waiting ? 4'd10 : round;
	assign lastRound = (round == 4'd0);

	keyExpander keys (
		.clk(clk),
		.reset(reset),
		.load(accept),
		.secretKey(request.secretKey),
		.select(select),
		.roundKey(roundKey),
		.ready(keyReady)
	);

	invRound rounds (
		.state(state),
		.roundKey(roundKey),
		.lastRound(lastRound),
		.nextState(nextState)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			waiting <= 1'b0;
			round <= 4'd0;
			done <= 1'b0;
			plainText <= '0;
		end else begin
			done <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				waiting <= 1'b1;
			end else if (busy && waiting) begin
				if (keyReady) begin
					waiting <= 1'b0; // the initial key addition happens on this edge.
					round <= 4'd9;
				end
			end else if (busy) begin
				if (lastRound) begin
					busy <= 1'b0;
					done <= 1'b1;
					plainText <= nextState.flat;
				end else begin
					round <= round - 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cipherText <= request.cipherText;
		end
		if (busy && waiting && keyReady) begin
			state.flat <= cipherText ^ roundKey; // select is 10 while waiting.
		end else if (busy && !waiting) begin
			state <= nextState;
		end
	end

endmodule

//--- aesDecrypt_props.sv
`timescale 1ns/1ps

module aesDecrypt_props (
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic done
);

	doneSingle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done stayed high for two cycles in a row");

	startRaisesBusy: assert property (@(posedge clk) disable iff (reset)
		(start && !busy) |=> busy)
		else $error("busy did not rise after an accepted start");

	// the first reset edge still sees the power-up value of done.
	quietInReset: assert property (@(posedge clk) (reset && $past(reset)) |-> !done)
		else $error("done was high while reset was active");

endmodule

bind aesDecrypt aesDecrypt_props props (
	.clk(clk),
	.reset(reset),
	.start(start),
	.busy(busy),
	.done(done)
);

//--- aesDecryptChecker.sv
`timescale 1ns/1ps

module aesDecryptChecker (
	input logic clk,
	input logic reset,
	input logic start,
	input aesPkg::aesRequest request,
	input logic busy,
	input logic done,
	input aesPkg::aesBlock plainText,
	output int errorCount,
	output int blockCount
);
	import aesPkg::*;

	localparam int latency = 21;
	localparam aesBlock knownKey = 128'h000102030405060708090a0b0c0d0e0f;
	localparam aesBlock knownCipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam aesBlock knownPlain = 128'h00112233445566778899aabbccddeeff;

	int errors = 0;
	int blocks = 0;
	int cycles = 0; // edges since the accepting edge.
	logic pending = 1'b0;
	logic holdValid = 1'b0;
	logic resetSeen = 1'b0;
	logic known = 1'b0;
	aesBlock expected;
	aesBlock held;

	assign errorCount = errors;
	assign blockCount = blocks;

	// Byte n of a block is row n%4 of column n/4, byte 0 in the top bits.
	function automatic aesBlock modelDecrypt(input aesRequest req);
		logic [31:0] w [44];
		logic [31:0] temp;
		logic [7:0] s [16];
		logic [7:0] t [16];
		logic [3:0] coef [4];
		aesBlock result;
		coef[0] = 4'he;
		coef[1] = 4'hb;
		coef[2] = 4'hd;
		coef[3] = 4'h9;
		for (int i = 0; i < 4; i++) begin
			w[i] = req.secretKey[127 - 32*i -: 32];
		end
		for (int i = 4; i < 44; i++) begin
			temp = w[i-1];
			if (i % 4 == 0) begin
				temp = {temp[23:0], temp[31:24]};
				temp = {sBox[temp[31:24]], sBox[temp[23:16]], sBox[temp[15:8]], sBox[temp[7:0]]};
				temp[31:24] = temp[31:24] ^ roundConstant[i/4 - 1];
			end
			w[i] = w[i-4] ^ temp;
		end
		for (int n = 0; n < 16; n++) begin
			s[n] = req.cipherText[127 - 8*n -: 8] ^ w[40 + n/4][31 - 8*(n%4) -: 8];
		end
		for (int round = 9; round >= 0; round--) begin
			for (int c = 0; c < 4; c++) begin
				for (int r = 0; r < 4; r++) begin
					t[4*((c + r) % 4) + r] = invSBox[s[4*c + r]]; // undo the left rotation of row r.
				end
			end
			for (int n = 0; n < 16; n++) begin
				t[n] = t[n] ^ w[4*round + n/4][31 - 8*(n%4) -: 8];
			end
			for (int c = 0; c < 4; c++) begin
				for (int r = 0; r < 4; r++) begin
					if (round == 0) begin
						s[4*c + r] = t[4*c + r];
					end else begin
						s[4*c + r] = 8'h00;
						for (int k = 0; k < 4; k++) begin
							s[4*c + r] = s[4*c + r] ^ gfMul(t[4*c + k], coef[(k - r + 4) % 4]);
						end
					end
				end
			end
		end
		for (int n = 0; n < 16; n++) begin
			result[127 - 8*n -: 8] = s[n];
		end
		return result;
	endfunction

	always @(posedge clk) begin
		if (resetSeen && (busy !== 1'b0 || done !== 1'b0 || plainText !== '0)) begin
			$display("ERROR %0t: outputs not cleared by reset (busy %b done %b plainText %h)",
				$time, busy, done, plainText);
			errors++;
		end
		resetSeen <= reset;
		if (reset) begin
			pending <= 1'b0;
			holdValid <= 1'b0;
		end else begin
			if (pending) begin
				if (done) begin
					if (cycles != latency + 1) begin
						$display("ERROR %0t: done rose %0d cycles after start, expected %0d",
							$time, cycles - 1, latency);
						errors++;
					end
					if (busy !== 1'b0) begin
						$display("ERROR %0t: busy still high after done", $time);
						errors++;
					end
					if (plainText !== expected) begin
						$display("ERROR %0t: plainText %h, expected %h", $time, plainText, expected);
						errors++;
					end
					if (known && plainText !== knownPlain) begin
						$display("ERROR %0t: known answer %h, expected %h", $time, plainText, knownPlain);
						errors++;
					end
					blocks++;
					pending <= 1'b0;
					holdValid <= 1'b1;
					held <= plainText;
				end else begin
					if (cycles == latency + 1) begin
						$display("ERROR %0t: done missing %0d cycles after start", $time, latency);
						errors++;
					end else if (busy !== 1'b1) begin
						$display("ERROR %0t: busy low %0d cycles into a block", $time, cycles);
						errors++;
					end
					cycles <= cycles + 1;
				end
			end else begin
				if (done !== 1'b0) begin
					$display("ERROR %0t: done pulse without a block in flight", $time);
					errors++;
				end
				if (holdValid && plainText !== held) begin
					$display("ERROR %0t: plainText changed while idle to %h, held %h",
						$time, plainText, held);
					errors++;
				end
			end
			if (start && (!pending || cycles == latency + 1)) begin
				pending <= 1'b1;
				holdValid <= 1'b0;
				cycles <= 1;
				expected <= modelDecrypt(request);
				known <= (request.secretKey == knownKey) && (request.cipherText == knownCipher);
			end
		end
	end

endmodule

//--- tb_aesDecrypt.sv
`timescale 1ns/1ps

module tb_aesDecrypt;
	import aesPkg::*;

	localparam int randomBlocks = 200;
	localparam int doneTimeout = 40;

	logic clk = 1'b0;
	logic reset;
	logic start;
	aesRequest request;
	logic busy;
	logic done;
	aesBlock plainText;
	int errorCount;
	int blockCount;
	int timeouts = 0;
	logic [31:0] lfsr = 32'd92510;

	always #5 clk = ~clk;

	aesDecrypt dut_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.request(request),
		.busy(busy),
		.done(done),
		.plainText(plainText)
	);

	aesDecryptChecker watcher (
		.clk(clk),
		.reset(reset),
		.start(start),
		.request(request),
		.busy(busy),
		.done(done),
		.plainText(plainText),
		.errorCount(errorCount),
		.blockCount(blockCount)
	);

	function automatic logic [31:0] lfsrStep(input logic [31:0] current);
		return current[0] ? ((current >> 1) ^ 32'h80200003) : (current >> 1);
	endfunction

	task automatic drawBits(input int count, output logic [127:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[126:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
	endtask

	// A stray start carries the inverted request while the block is busy.
	task automatic sendBlock(input aesRequest req, input int gap, input logic strayStart);
		int waited;
		repeat (gap) @(negedge clk);
		request = req;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (strayStart) begin
			@(negedge clk);
			request = ~req;
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		waited = 0;
		while (done !== 1'b1 && waited < doneTimeout) begin
			@(negedge clk);
			waited++;
		end
		if (done !== 1'b1) begin
			$display("timeout: done did not rise within %0d cycles", doneTimeout);
			timeouts++;
		end
		@(negedge clk);
	endtask

	initial begin
		aesRequest req;
		logic [127:0] bits;
		int gap;
		logic stray;
		reset = 1'b1;
		start = 1'b0;
		request = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);
		req.secretKey = 128'h000102030405060708090a0b0c0d0e0f;
		req.cipherText = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
		sendBlock(req, 0, 1'b0);
		for (int i = 0; i < randomBlocks; i++) begin
			if (timeouts != 0) begin
				break;
			end
			drawBits(128, bits);
			req.secretKey = bits;
			drawBits(128, bits);
			req.cipherText = bits;
			drawBits(2, bits);
			gap = int'(bits[1:0]);
			drawBits(1, bits);
			stray = bits[0];
			sendBlock(req, gap, stray);
		end
		repeat (3) @(negedge clk);
		$display("blocks checked: %0d, errors: %0d, timeouts: %0d", blockCount, errorCount, timeouts);
		if (errorCount == 0 && timeouts == 0 && blockCount == randomBlocks + 1) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- aesDecrypt.f
aesPkg.sv
invMixColumns.sv
invRound.sv
keyExpander.sv
aesDecrypt.sv
aesDecrypt_props.sv
aesDecryptChecker.sv
tb_aesDecrypt.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS ?= --timing --assert
TOP ?= tb_aesDecrypt
FILELIST ?= aesDecrypt.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT = === PASS ===

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
